// ==== design/raster_pkg.sv ====
// raster package
// opcodes, command word fields, widths and the structs passed between
// the decoder, the producers and the memory writer

package raster_pkg;

    typedef enum logic [3:0] {
        OP_SET_X0    = 4'd0,
        OP_SET_Y0    = 4'd1,
        OP_SET_X1    = 4'd2,
        OP_SET_Y1    = 4'd3,
        OP_SET_X2    = 4'd4,
        OP_SET_Y2    = 4'd5,
        OP_SET_COLOR = 4'd6,
        OP_CLEAR     = 4'd7,
        OP_DRAW      = 4'd8
    } op_e;

    // command word layout
    localparam int OP_POS       = 20;
    localparam int OP_SIZE      = 4;
    localparam int HALF_SEL_BIT = 16;

    localparam int CMD_W       = 32;
    localparam int COORD_W     = 12;
    localparam int COLOR_W     = 16;
    localparam int VRAM_ADDR_W = 32;

    // 16.16 fixed point position
    typedef struct packed {
        logic signed [31:0] x;
        logic signed [31:0] y;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } tri_t;

    typedef struct packed {
        logic signed [COORD_W-1:0] x;
        logic signed [COORD_W-1:0] y;
        logic [VRAM_ADDR_W-1:0]    addr;
    } pixel_t;

    typedef struct packed {
        logic [VRAM_ADDR_W-1:0] addr;
        logic                   covered;
    } frag_t;

    typedef struct packed {
        logic [VRAM_ADDR_W-1:0] addr;
        logic [COLOR_W-1:0]     data;
    } vram_req_t;

endpackage

// ==== design/cmd_decoder.sv ====
// command decoder
// holds the vertex and colour registers and launches clear and draw jobs

`timescale 1ns/1ps

module cmd_decoder #(
    parameter logic [15:0] SUBPIXEL_MASK = 16'hF000
) (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              cmd_valid_i,
    output logic                              cmd_ready_o,
    input  logic [raster_pkg::CMD_W-1:0]      cmd_data_i,
    input  logic                              clear_busy_i,
    input  logic                              draw_busy_i,
    input  logic                              write_busy_i,
    output raster_pkg::tri_t                  tri_o,
    output logic [raster_pkg::COLOR_W-1:0]    color_o,
    output logic                              clear_start_o,
    output logic [raster_pkg::COLOR_W-1:0]    clear_color_o,
    output logic                              draw_start_o
);
    import raster_pkg::*;

    localparam int WORD_W = $bits(vertex_t) / 2;
    localparam int HALF_W = WORD_W / 2;

    op_e          op;
    logic [15:0]  value;
    logic         accept;
    int           word_base;

    assign op     = op_e'(cmd_data_i[OP_POS +: OP_SIZE]);
    assign value  = cmd_data_i[15:0];
    assign accept = cmd_valid_i && cmd_ready_o;

    // the start pulse covers the cycle before the producer reports busy
    assign cmd_ready_o = !(clear_start_o || draw_start_o ||
                           clear_busy_i || draw_busy_i || write_busy_i);

    // v0.x sits in the top word of the triangle, v2.y in the bottom one
    assign word_base = (5 - int'(op)) * WORD_W;

    always_ff @(posedge clk) begin
        if (accept && op <= OP_SET_Y2) begin
            if (cmd_data_i[HALF_SEL_BIT]) begin
                tri_o[word_base + HALF_W +: HALF_W] <= value;
            end else begin
                tri_o[word_base +: HALF_W] <= value & SUBPIXEL_MASK;
            end
        end
        if (accept && op == OP_SET_COLOR) begin
            color_o <= value;
        end
        if (accept && op == OP_CLEAR) begin
            clear_color_o <= value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            clear_start_o <= 1'b0;
            draw_start_o  <= 1'b0;
        end else begin
            clear_start_o <= accept && op == OP_CLEAR;
            draw_start_o  <= accept && op == OP_DRAW;
        end
    end

    // a job never starts on top of another one
    assert property (@(posedge clk) disable iff (reset_i)
        (clear_start_o || draw_start_o) |-> !(clear_busy_i || draw_busy_i || write_busy_i))
        else $error("start pulse while a job is busy");

endmodule

// ==== design/clear_gen.sv ====
// clear generator
// one write request per frame-buffer word, all carrying the clear colour

`timescale 1ns/1ps

module clear_gen #(
    parameter int FB_WIDTH  = 128,
    parameter int FB_HEIGHT = 128
) (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              start_i,
    input  logic [raster_pkg::COLOR_W-1:0]    color_i,
    output logic                              req_valid_o,
    input  logic                              req_ready_i,
    output raster_pkg::vram_req_t             req_o,
    output logic                              busy_o
);
    import raster_pkg::*;

    localparam logic [VRAM_ADDR_W-1:0] LAST_ADDR = VRAM_ADDR_W'(FB_WIDTH * FB_HEIGHT - 1);

    logic                   active_q;
    logic [VRAM_ADDR_W-1:0] addr_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            active_q <= 1'b0;
        end else if (start_i) begin
            active_q <= 1'b1;
            addr_q   <= '0;
        end else if (active_q && req_ready_i) begin
            if (addr_q == LAST_ADDR) begin
                active_q <= 1'b0;
            end
            addr_q <= addr_q + 1'b1;
        end
    end

    assign req_valid_o = active_q;
    assign req_o       = '{addr: addr_q, data: color_i};
    assign busy_o      = active_q;

endmodule

// ==== design/pixel_walker.sv ====
// pixel walker
// finds the triangle's bounding box, clamps it to the screen and
// streams its pixels row by row with running frame-buffer addresses

`timescale 1ns/1ps

module pixel_walker #(
    parameter int FB_WIDTH  = 128,
    parameter int FB_HEIGHT = 128
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               start_i,
    input  raster_pkg::tri_t   tri_i,
    output logic               pix_valid_o,
    input  logic               pix_ready_i,
    output raster_pkg::pixel_t pix_o,
    input  logic               pipe_busy_i,
    output logic               busy_o
);
    import raster_pkg::*;

    typedef logic signed [COORD_W-1:0] coord_t;

    localparam coord_t X_LAST = COORD_W'(FB_WIDTH - 1);
    localparam coord_t Y_LAST = COORD_W'(FB_HEIGHT - 1);

    typedef enum logic [1:0] {W_IDLE, W_BOX, W_CLAMP, W_WALK} state_e;

    state_e                 state;
    coord_t                 x0, y0, x1, y1, x2, y2;
    coord_t                 min_x_q, min_y_q, max_x_q, max_y_q;
    coord_t                 cmin_x, cmin_y, cmax_x, cmax_y;
    coord_t                 x_q, y_q;
    logic [VRAM_ADDR_W-1:0] addr_q;
    logic [VRAM_ADDR_W-1:0] row_step;

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // integer parts of the 16.16 coordinates
    assign x0 = tri_i.v0.x[16 +: COORD_W];
    assign y0 = tri_i.v0.y[16 +: COORD_W];
    assign x1 = tri_i.v1.x[16 +: COORD_W];
    assign y1 = tri_i.v1.y[16 +: COORD_W];
    assign x2 = tri_i.v2.x[16 +: COORD_W];
    assign y2 = tri_i.v2.y[16 +: COORD_W];

    always_comb begin
        cmin_x = (min_x_q < 0) ? '0 : min_x_q;
        cmin_y = (min_y_q < 0) ? '0 : min_y_q;
        cmax_x = (max_x_q > X_LAST) ? X_LAST : max_x_q;
        cmax_y = (max_y_q > Y_LAST) ? Y_LAST : max_y_q;
    end

    // jump from the row end back to min_x on the next row
    assign row_step = VRAM_ADDR_W'(FB_WIDTH) - VRAM_ADDR_W'(max_x_q - min_x_q);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE: if (start_i) state <= W_BOX;
                W_BOX: begin
                    min_x_q <= min3(x0, x1, x2);
                    min_y_q <= min3(y0, y1, y2);
                    max_x_q <= max3(x0, x1, x2);
                    max_y_q <= max3(y0, y1, y2);
                    state   <= W_CLAMP;
                end
                W_CLAMP: begin
                    min_x_q <= cmin_x;
                    min_y_q <= cmin_y;
                    max_x_q <= cmax_x;
                    max_y_q <= cmax_y;
                    x_q     <= cmin_x;
                    y_q     <= cmin_y;
                    addr_q  <= VRAM_ADDR_W'(cmin_y) * FB_WIDTH + VRAM_ADDR_W'(cmin_x);
                    // box fully off screen or inverted
                    state   <= (cmin_x > cmax_x || cmin_y > cmax_y) ? W_IDLE : W_WALK;
                end
                W_WALK: if (pix_ready_i) begin
                    if (x_q == max_x_q) begin
                        if (y_q == max_y_q) state <= W_IDLE;
                        x_q    <= min_x_q;
                        y_q    <= y_q + 1'b1;
                        addr_q <= addr_q + row_step;
                    end else begin
                        x_q    <= x_q + 1'b1;
                        addr_q <= addr_q + 1'b1;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    assign pix_valid_o = state == W_WALK;
    assign pix_o       = '{x: x_q, y: y_q, addr: addr_q};
    assign busy_o      = state != W_IDLE || pipe_busy_i;

endmodule

// ==== design/edge_eval.sv ====
// edge evaluator
// three-stage pipeline computing the three edge functions per pixel;
// a pixel is covered when no edge function is negative

`timescale 1ns/1ps

module edge_eval (
    input  logic               clk,
    input  logic               reset_i,
    input  raster_pkg::tri_t   tri_i,
    input  logic               pix_valid_i,
    output logic               pix_ready_o,
    input  raster_pkg::pixel_t pix_i,
    output logic               frag_valid_o,
    input  logic               frag_ready_i,
    output raster_pkg::frag_t  frag_o,
    output logic               busy_o
);
    import raster_pkg::*;

    vertex_t                va [3];
    vertex_t                vb [3];
    logic signed [31:0]     px, py;
    logic                   en;

    logic                   s1_valid, s2_valid, s3_valid;
    logic [VRAM_ADDR_W-1:0] s1_addr, s2_addr;
    logic signed [31:0]     s1_pdx [3];
    logic signed [31:0]     s1_pdy [3];
    logic signed [31:0]     s1_ex  [3];
    logic signed [31:0]     s1_ey  [3];
    logic signed [31:0]     s2_t0  [3];
    logic signed [31:0]     s2_t1  [3];
    logic signed [31:0]     w      [3];

    // edge i runs from va[i] to vb[i]: (1,2), (2,0), (0,1)
    assign va[0] = tri_i.v1;
    assign vb[0] = tri_i.v2;
    assign va[1] = tri_i.v2;
    assign vb[1] = tri_i.v0;
    assign va[2] = tri_i.v0;
    assign vb[2] = tri_i.v1;

    // pixel corner in 16.16
    assign px = {{(16 - COORD_W){pix_i.x[COORD_W-1]}}, pix_i.x, 16'd0};
    assign py = {{(16 - COORD_W){pix_i.y[COORD_W-1]}}, pix_i.y, 16'd0};

    // the whole pipe moves only when the writer can take a fragment
    assign en          = frag_ready_i;
    assign pix_ready_o = en;

    always_ff @(posedge clk) begin
        if (en) begin
            s1_addr <= pix_i.addr;
            s2_addr <= s1_addr;
            for (int i = 0; i < 3; i++) begin
                s1_pdx[i] <= (px - va[i].x) >>> 8;
                s1_pdy[i] <= (py - va[i].y) >>> 8;
                s1_ex[i]  <= (vb[i].x - va[i].x) >>> 8;
                s1_ey[i]  <= (vb[i].y - va[i].y) >>> 8;
                s2_t0[i]  <= s1_pdx[i] * s1_ey[i];
                s2_t1[i]  <= s1_pdy[i] * s1_ex[i];
            end
            frag_o <= '{addr: s2_addr, covered: !(w[0][31] || w[1][31] || w[2][31])};
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            w[i] = s2_t0[i] - s2_t1[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (en) begin
            s1_valid <= pix_valid_i;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    assign frag_valid_o = s3_valid;
    assign busy_o       = s1_valid || s2_valid || s3_valid;

    assert property (@(posedge clk) disable iff (reset_i)
        frag_valid_o && !frag_ready_i |=> frag_valid_o && $stable(frag_o))
        else $error("stalled fragment changed");

endmodule

// ==== design/vram_writer.sv ====
// memory writer
// merges clear requests and covered fragments into sel/ack bus writes

`timescale 1ns/1ps

module vram_writer #(
    parameter int FB_WORDS = 128 * 128
) (
    input  logic                                 clk,
    input  logic                                 reset_i,
    input  logic                                 req_valid_i,
    output logic                                 req_ready_o,
    input  raster_pkg::vram_req_t                req_i,
    input  logic                                 frag_valid_i,
    output logic                                 frag_ready_o,
    input  raster_pkg::frag_t                    frag_i,
    input  logic [raster_pkg::COLOR_W-1:0]       color_i,
    input  logic                                 vram_ack_i,
    output logic                                 vram_sel_o,
    output logic                                 vram_wr_o,
    output logic [raster_pkg::VRAM_ADDR_W-1:0]   vram_addr_o,
    output logic [raster_pkg::COLOR_W-1:0]       vram_data_o,
    output logic                                 busy_o
);
    import raster_pkg::*;

    logic      sel_q;
    vram_req_t bus_q;

    // clear requests win over fragments
    assign req_ready_o  = !sel_q;
    assign frag_ready_o = !sel_q && !req_valid_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sel_q <= 1'b0;
        end else if (sel_q) begin
            if (vram_ack_i) sel_q <= 1'b0;
        end else if (req_valid_i) begin
            sel_q <= 1'b1;
            bus_q <= req_i;
        end else if (frag_valid_i && frag_i.covered) begin
            sel_q <= 1'b1;
            bus_q <= '{addr: frag_i.addr, data: color_i};
        end
    end

    assign vram_sel_o  = sel_q;
    assign vram_wr_o   = sel_q;
    assign vram_addr_o = bus_q.addr;
    assign vram_data_o = bus_q.data;
    assign busy_o      = sel_q;

    assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |-> vram_addr_o < FB_WORDS)
        else $error("write outside the frame buffer");

    assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o && !vram_ack_i |=> vram_sel_o && $stable(vram_addr_o) && $stable(vram_data_o))
        else $error("bus changed before ack");

endmodule

// ==== design/raster_top.sv ====
// triangle rasterizer top level
// command decoder feeding a clear generator and a walker/edge pipeline,
// both merged into one write-only video memory bus

`timescale 1ns/1ps

module raster_top #(
    parameter int          FB_WIDTH      = 128,
    parameter int          FB_HEIGHT     = 128,
    parameter logic [15:0] SUBPIXEL_MASK = 16'hF000
) (
    input  logic                               clk,
    input  logic                               reset_i,
    input  logic                               cmd_valid_i,
    output logic                               cmd_ready_o,
    input  logic [raster_pkg::CMD_W-1:0]       cmd_data_i,
    input  logic                               vram_ack_i,
    output logic                               vram_sel_o,
    output logic                               vram_wr_o,
    output logic [raster_pkg::VRAM_ADDR_W-1:0] vram_addr_o,
    output logic [raster_pkg::COLOR_W-1:0]     vram_data_o
);
    import raster_pkg::*;

    tri_t               tri_v;
    logic [COLOR_W-1:0] color, clear_color;
    logic               clear_start, draw_start;
    logic               clear_busy, draw_busy, pipe_busy, write_busy;
    logic               req_valid, req_ready;
    vram_req_t          req;
    logic               pix_valid, pix_ready;
    pixel_t             pix;
    logic               frag_valid, frag_ready;
    frag_t              frag;

    cmd_decoder #(.SUBPIXEL_MASK(SUBPIXEL_MASK)) u_decoder (
        .clk, .reset_i, .cmd_valid_i, .cmd_ready_o, .cmd_data_i,
        .clear_busy_i(clear_busy), .draw_busy_i(draw_busy), .write_busy_i(write_busy),
        .tri_o(tri_v), .color_o(color), .clear_start_o(clear_start),
        .clear_color_o(clear_color), .draw_start_o(draw_start)
    );

    clear_gen #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_clear (
        .clk, .reset_i, .start_i(clear_start), .color_i(clear_color),
        .req_valid_o(req_valid), .req_ready_i(req_ready), .req_o(req), .busy_o(clear_busy)
    );

    pixel_walker #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_walker (
        .clk, .reset_i, .start_i(draw_start), .tri_i(tri_v),
        .pix_valid_o(pix_valid), .pix_ready_i(pix_ready), .pix_o(pix),
        .pipe_busy_i(pipe_busy), .busy_o(draw_busy)
    );

    edge_eval u_edge (
        .clk, .reset_i, .tri_i(tri_v),
        .pix_valid_i(pix_valid), .pix_ready_o(pix_ready), .pix_i(pix),
        .frag_valid_o(frag_valid), .frag_ready_i(frag_ready), .frag_o(frag),
        .busy_o(pipe_busy)
    );

    vram_writer #(.FB_WORDS(FB_WIDTH * FB_HEIGHT)) u_writer (
        .clk, .reset_i,
        .req_valid_i(req_valid), .req_ready_o(req_ready), .req_i(req),
        .frag_valid_i(frag_valid), .frag_ready_o(frag_ready), .frag_i(frag),
        .color_i(color), .vram_ack_i, .vram_sel_o, .vram_wr_o, .vram_addr_o,
        .vram_data_o, .busy_o(write_busy)
    );

endmodule

// ==== test/raster_tb.sv ====
// raster testbench
// replays command vectors into the rasterizer, models a 16x8 frame buffer
// with random ack delays and checks write counts, spot pixels and the bus

`timescale 1ns/1ps

module raster_tb;
    import raster_pkg::*;

    localparam int FB_WIDTH  = 16;
    localparam int FB_HEIGHT = 8;
    localparam int FB_WORDS  = FB_WIDTH * FB_HEIGHT;

    logic                   clk = 1'b0;
    logic                   reset_i;
    logic                   cmd_valid_i;
    logic                   cmd_ready_o;
    logic [CMD_W-1:0]       cmd_data_i;
    logic                   vram_ack_i = 1'b0;
    logic                   vram_sel_o;
    logic                   vram_wr_o;
    logic [VRAM_ADDR_W-1:0] vram_addr_o;
    logic [COLOR_W-1:0]     vram_data_o;

    logic [COLOR_W-1:0] mem [FB_WORDS];
    int                 hits [FB_WORDS];
    byte                kind_q [$];
    logic [31:0]        arg0_q [$];
    logic [31:0]        arg1_q [$];
    logic [31:0]        arg2_q [$];
    int                 errors = 0;
    int                 checks = 0;
    int                 write_count = 0;
    int                 cycles = 0;
    int                 cycle_limit = 0;
    logic [31:0]        rng = 32'd95;
    int                 wait_left = 0;
    logic               waiting = 1'b0;
    logic               held = 1'b0;
    vram_req_t          held_req;
    logic               job_is_clear = 1'b0;
    logic [COLOR_W-1:0] job_color = '0;
    logic               opened;

    raster_top #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) DUT (
        .clk, .reset_i, .cmd_valid_i, .cmd_ready_o, .cmd_data_i,
        .vram_ack_i, .vram_sel_o, .vram_wr_o, .vram_addr_o, .vram_data_o
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic log_mismatch(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic log_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic report_and_stop();
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic load_vectors(output logic ok);
        int          fd;
        int          total;
        string       line;
        byte         tag;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        total = 0;
        fd = $fopen("test/raster_vectors.txt", "r");
        ok = fd != 0;
        if (ok) begin
            while ($fgets(line, fd) > 0) begin
                tag = line.getc(0);
                a = '0;
                b = '0;
                c = '0;
                if (tag == "C" || tag == "N" || tag == "P") begin
                    if (tag == "C") begin
                        void'($sscanf(line, "C %h", a));
                    end else if (tag == "N") begin
                        void'($sscanf(line, "N %d", a));
                        total += a;
                    end else begin
                        void'($sscanf(line, "P %d %d %h", a, b, c));
                    end
                    kind_q.push_back(tag);
                    arg0_q.push_back(a);
                    arg1_q.push_back(b);
                    arg2_q.push_back(c);
                end else if (tag != "#" && tag != "\n" && tag != 0) begin
                    log_failure($sformatf("vector file line not understood: %s", line));
                end
            end
            $fclose(fd);
        end
        cycle_limit = 20 * total + 2000;
    endtask

    task automatic store_write();
        checks++;
        write_count++;
        assert (vram_addr_o < FB_WORDS) else
            log_mismatch($sformatf("write to %h lies outside the frame buffer", vram_addr_o));
        if (vram_addr_o < FB_WORDS) begin
            mem[vram_addr_o] = vram_data_o;
            hits[vram_addr_o]++;
        end
    endtask

    task automatic send_command(input logic [CMD_W-1:0] word);
        logic [OP_SIZE-1:0] op;
        logic               is_job;
        op = word[OP_POS +: OP_SIZE];
        is_job = op == OP_CLEAR || op == OP_DRAW;
        while (!cmd_ready_o) begin
            @(posedge clk);
            #1;
        end
        if (is_job) begin
            job_is_clear = op == OP_CLEAR;
            job_color = word[COLOR_W-1:0];
            foreach (hits[i]) begin
                hits[i] = 0;
            end
        end
        cmd_valid_i = 1'b1;
        cmd_data_i = word;
        @(posedge clk);
        #1;
        cmd_valid_i = 1'b0;
        checks++;
        assert (cmd_ready_o == !is_job) else
            log_mismatch($sformatf("cmd_ready_o is %b after command %h", cmd_ready_o, word));
    endtask

    task automatic check_job_count(input int expected);
        while (!cmd_ready_o) begin
            @(posedge clk);
            #1;
        end
        checks++;
        assert (!vram_sel_o) else
            log_mismatch("cmd_ready_o returned while a write was still open");
        assert (write_count == expected) else
            log_mismatch($sformatf("job wrote %0d words, expected %0d", write_count, expected));
        foreach (hits[i]) begin
            if (job_is_clear) begin
                assert (hits[i] == 1 && mem[i] == job_color) else
                    log_mismatch($sformatf("clear left word %0d at %h after %0d writes",
                                           i, mem[i], hits[i]));
            end else begin
                assert (hits[i] <= 1) else
                    log_mismatch($sformatf("draw wrote word %0d %0d times", i, hits[i]));
            end
        end
        write_count = 0;
    endtask

    task automatic check_pixel(input int x, input int y, input logic [COLOR_W-1:0] expected);
        int addr;
        addr = y * FB_WIDTH + x;
        checks++;
        assert (mem[addr] == expected) else
            log_mismatch($sformatf("pixel (%0d,%0d) holds %h, expected %h",
                                   x, y, mem[addr], expected));
    endtask

    // the memory model takes a write on the edge where sel and ack are both high
    always @(posedge clk) begin
        if (!reset_i && vram_sel_o) begin
            checks++;
            assert (vram_wr_o && !cmd_ready_o) else
                log_mismatch("write strobe or cmd_ready_o wrong during a bus cycle");
            if (held) begin
                assert (vram_addr_o == held_req.addr && vram_data_o == held_req.data) else
                    log_mismatch($sformatf("bus changed before ack to addr %h data %h",
                                           vram_addr_o, vram_data_o));
            end
            held_req = '{addr: vram_addr_o, data: vram_data_o};
            held = !vram_ack_i;
            if (vram_ack_i) begin
                store_write();
            end
        end else begin
            held = 1'b0;
        end
        #1;
        if (reset_i || !vram_sel_o || vram_ack_i) begin
            vram_ack_i = 1'b0;
        end else begin
            // 0 to 3 wait cycles per write
            if (!waiting) begin
                rng = xorshift32(rng);
                wait_left = rng % 4;
                waiting = 1'b1;
            end
            if (wait_left == 0) begin
                vram_ack_i = 1'b1;
                waiting = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            log_failure($sformatf("timeout after %0d cycles, the DUT never finished", cycles));
            report_and_stop();
        end
    end

    initial begin
        reset_i = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_data_i = '0;
        for (int i = 0; i < FB_WORDS; i++) begin
            mem[i] = 16'hA500 ^ 16'(i);
            hits[i] = 0;
        end
        load_vectors(opened);
        if (!opened) begin
            log_failure("cannot open the vector file test/raster_vectors.txt");
            report_and_stop();
        end else begin
            repeat (3) @(posedge clk);
            #1;
            reset_i = 1'b0;
            checks++;
            assert (cmd_ready_o && !vram_sel_o && !vram_wr_o) else
                log_mismatch("DUT not idle after reset");
            foreach (kind_q[i]) begin
                case (kind_q[i])
                    "C": send_command(arg0_q[i]);
                    "N": check_job_count(arg0_q[i]);
                    default: check_pixel(arg0_q[i], arg1_q[i], arg2_q[i][COLOR_W-1:0]);
                endcase
            end
            report_and_stop();
        end
    end

endmodule

// ==== test/raster_vectors.txt ====
# C <command hex> | N <writes expected for the job just issued> | P <x> <y> <colour hex>
# frame buffer is 16x8, address is y*16+x
C 00701111
N 128
P 0 0 1111
P 15 7 1111
C 00010002
C 00000FFF
C 00110001
C 00100000
C 00210002
C 00200000
C 00310006
C 00300000
C 0041000A
C 00400000
C 00510001
C 005000AB
C 006007E0
C 00800000
N 28
P 2 1 07E0
P 10 1 07E0
P 2 6 07E0
P 9 2 1111
P 3 6 1111
P 1 1 1111
# triangle reaching off screen on three sides
C 0001FFFD
C 0011FFFE
C 0021FFFD
C 0031000C
C 00410014
C 0051FFFE
C 0060F800
C 00800000
N 91
P 0 0 F800
P 15 1 F800
P 15 2 1111
P 5 7 F800
P 6 7 1111
# same triangle wound clockwise
C 00210014
C 0031FFFE
C 0041FFFD
C 0051000C
C 00800000
N 0
P 4 2 F800

// ==== list.f ====
design/raster_pkg.sv
design/cmd_decoder.sv
design/clear_gen.sv
design/pixel_walker.sv
design/edge_eval.sv
design/vram_writer.sv
design/raster_top.sv
test/raster_tb.sv

// ==== Bender.yml ====
package:
  name: raster

sources:
  - design/raster_pkg.sv
  - design/cmd_decoder.sv
  - design/clear_gen.sv
  - design/pixel_walker.sv
  - design/edge_eval.sv
  - design/vram_writer.sv
  - design/raster_top.sv
  - target: test
    files:
      - test/raster_tb.sv
